// File: logic/lau_settings.svh
`ifndef LAU_SETTINGS_SVH
`define LAU_SETTINGS_SVH

// default width of the carry-save multiplier words xs and xc
// keep it at or below the multiplicand width
`define LAU_WIDTH_X 8

// default width of the binary multiplicand y
`define LAU_WIDTH_Y 8

// default adder structure
`define LAU_SPEED lau_pkg::FAST

`endif

// File: logic/lau_pkg.sv
package lau_pkg;

	// structure choice for the adders of the library
	// slow variants trade delay for area
	// fast variants use prefix carry networks and compressor trees
	typedef enum logic [1:0] {
		// ripple carry and linear compressor chain
		SLOW = 2'd0,
		// sklansky prefix carries and wallace tree
		FAST = 2'd1
	} speed_e;

endpackage

// File: logic/AddMulPPGenUns.sv
`timescale 1ns/1ps

module AddMulPPGenUns #(
	// width of the carry-save multiplier words
	parameter int widthX = 8,
	// width of the multiplicand
	parameter int widthY = 8
) (
	input logic [widthX-1:0] xs,
	input logic [widthX-1:0] xc,
	input logic [widthY-1:0] y,
	// one product-wide row per multiplier digit, row 0 in the low slice
	output logic [widthX*(widthX+widthY)-1:0] pp
);

	// product width, also the width of every row
	localparam int widthP = widthX + widthY;

	// multiplicand zero-extended to the row width
	logic [widthP-1:0] yExt;

	assign yExt = widthP'(y);

	// brown's method
	// each bit pair of xs and xc forms one digit in 0..2
	// the digit selects zero, y or 2y at the weight of its position
	for (genvar i = 0; i < widthX; i++) begin : gRow
		// digit value as a 2-bit binary number
		logic [1:0] digit;
		// selected multiple of y, already shifted
		logic [widthP-1:0] row;

		// half adder on the bit pair gives the digit directly
		assign digit = {xs[i] & xc[i], xs[i] ^ xc[i]};

		always_comb begin
			case (digit)
				// y at weight i
				2'd1: row = yExt << i;
				// 2y at weight i, same as y at weight i+1
				2'd2: row = yExt << (i + 1);
				// zero digit, value 3 cannot occur
				default: row = '0;
			endcase
		end

		// bits shifted past the product width drop out here
		assign pp[i*widthP +: widthP] = row;
	end

endmodule

// File: logic/AddMopCsv.sv
`timescale 1ns/1ps

module AddMopCsv #(
	// word width of every operand and of both results
	parameter int width = 16,
	// number of operands
	parameter int depth = 8,
	parameter lau_pkg::speed_e speed = lau_pkg::FAST
) (
	// operand k sits in slice k
	input logic [depth*width-1:0] a,
	output logic [width-1:0] s,
	output logic [width-1:0] c
);

	// operands left after one tree level
	// every full group of three turns into two words
	function automatic int nextCount(input int n);
		return 2 * (n / 3) + n % 3;
	endfunction

	// operands left after lvl tree levels
	function automatic int countAt(input int n, input int lvl);
		int rem;
		rem = n;
		for (int k = 0; k < lvl; k++) begin
			rem = nextCount(rem);
		end
		return rem;
	endfunction

	// tree levels needed to get down to two words
	function automatic int levelCount(input int n);
		int rem;
		int cnt;
		rem = n;
		cnt = 0;
		while (rem > 2) begin
			rem = nextCount(rem);
			cnt++;
		end
		return cnt;
	endfunction

	// one row of full adders
	// carry word in the upper half, sum word in the lower half
	function automatic logic [2*width-1:0] csa(
		input logic [width-1:0] x,
		input logic [width-1:0] y,
		input logic [width-1:0] z
	);
		logic [width-1:0] sum;
		logic [width-1:0] cry;
		sum = x ^ y ^ z;
		cry = (x & y) | (x & z) | (y & z);
		// carries move one place up, the top one is lost
		return {cry << 1, sum};
	endfunction

	localparam int levels = levelCount(depth);

	if (depth == 1) begin : gSingle
		// nothing to compress
		assign s = a[width-1:0];
		assign c = '0;
	end else if (speed == lau_pkg::SLOW) begin : gChain
		// running sum and carry after operand k has been added
		logic [width-1:0] runS [1:depth-1];
		logic [width-1:0] runC [1:depth-1];

		// first two operands start the chain as they are
		assign runS[1] = a[0 +: width];
		assign runC[1] = a[width +: width];

		// one compressor row per further operand
		for (genvar k = 2; k < depth; k++) begin : gStep
			assign {runC[k], runS[k]} = csa(runS[k-1], runC[k-1], a[k*width +: width]);
		end

		assign s = runS[depth-1];
		assign c = runC[depth-1];
	end else begin : gTree
		// words present at each level, unused slots tied low
		logic [width-1:0] lev [0:levels][0:depth-1];

		for (genvar k = 0; k < depth; k++) begin : gIn
			assign lev[0][k] = a[k*width +: width];
		end

		for (genvar l = 0; l < levels; l++) begin : gLevel
			localparam int nIn = countAt(depth, l);
			localparam int nGrp = nIn / 3;
			localparam int nOut = nextCount(nIn);

			// groups of three in parallel
			for (genvar g = 0; g < nGrp; g++) begin : gCsa
				assign {lev[l+1][2*g+1], lev[l+1][2*g]} =
					csa(lev[l][3*g], lev[l][3*g+1], lev[l][3*g+2]);
			end

			// leftover one or two words skip this level
			for (genvar k = 3 * nGrp; k < nIn; k++) begin : gPass
				assign lev[l+1][k-nGrp] = lev[l][k];
			end

			for (genvar k = nOut; k < depth; k++) begin : gIdle
				assign lev[l+1][k] = '0;
			end
		end

		assign s = lev[levels][0];
		assign c = lev[levels][1];
	end

endmodule

// File: logic/Add.sv
`timescale 1ns/1ps

module Add #(
	// word width of operands and sum
	parameter int width = 16,
	parameter lau_pkg::speed_e speed = lau_pkg::FAST
) (
	input logic [width-1:0] a,
	input logic [width-1:0] b,
	// sum modulo 2**width
	output logic [width-1:0] s
);

	// depth of the prefix network
	localparam int levels = $clog2(width);

	// carry into each bit position, cy[width] is the carry out
	logic [width:0] cy;

	// no carry in
	assign cy[0] = 1'b0;

	if (speed == lau_pkg::SLOW) begin : gRipple
		// one majority gate per bit, carries ripple upward
		for (genvar i = 0; i < width; i++) begin : gBit
			assign cy[i+1] = (a[i] & b[i]) | (cy[i] & (a[i] ^ b[i]));
		end
	end else begin : gPrefix
		// group generate and propagate after each level
		logic [levels:0][width-1:0] gen;
		logic [levels:0][width-1:0] prp;

		// bitwise generate and propagate
		assign gen[0] = a & b;
		assign prp[0] = a ^ b;

		// sklansky tree
		// at level l the upper half of each 2**(l+1) block
		// joins the prefix of the last bit of the lower half
		for (genvar l = 0; l < levels; l++) begin : gLevel
			for (genvar i = 0; i < width; i++) begin : gBit
				if (((i >> l) & 1) == 1) begin : gOp
					// last bit of the lower half block
					localparam int j = ((i >> l) << l) - 1;

					assign gen[l+1][i] = gen[l][i] | (prp[l][i] & gen[l][j]);
					assign prp[l+1][i] = prp[l][i] & prp[l][j];
				end else begin : gBuf
					// prefix already complete for this level
					assign gen[l+1][i] = gen[l][i];
					assign prp[l+1][i] = prp[l][i];
				end
			end
		end

		// prefix generate of bits 0..i is the carry into bit i+1
		assign cy[width:1] = gen[levels];
	end

	// half sum plus incoming carry
	assign s = a ^ b ^ cy[width-1:0];

endmodule

// File: logic/AddMulUns.sv
`timescale 1ns/1ps

module AddMulUns #(
	// width of xs and xc, at most widthY
	parameter int widthX = 8,
	// width of y
	parameter int widthY = 8,
	parameter lau_pkg::speed_e speed = lau_pkg::FAST
) (
	// multiplier in carry-save form
	input logic [widthX-1:0] xs,
	input logic [widthX-1:0] xc,
	// binary multiplicand
	input logic [widthY-1:0] y,
	// p = (xs + xc) * y, wraps if the sum overflows
	output logic [widthX+widthY-1:0] p
);

	// rows of the brown partial products
	logic [widthX*(widthX+widthY)-1:0] pp;
	// sum and carry words after compression
	logic [widthX+widthY-1:0] sumT;
	logic [widthX+widthY-1:0] cryT;

	// one row per carry-save digit
	AddMulPPGenUns #(
		.widthX(widthX),
		.widthY(widthY)
	) ppGen (
		.xs(xs),
		.xc(xc),
		.y (y),
		.pp(pp)
	);

	// widthX rows down to two words
	AddMopCsv #(
		.width(widthX + widthY),
		.depth(widthX),
		.speed(speed)
	) csvAdd (
		.a(pp),
		.s(sumT),
		.c(cryT)
	);

	// resolve the carry-save result
	Add #(
		.width(widthX + widthY),
		.speed(speed)
	) cpAdd (
		.a(sumT),
		.b(cryT),
		.s(p)
	);

endmodule

// File: logic/AddMulUnit.sv
`timescale 1ns/1ps
`include "lau_settings.svh"

module AddMulUnit #(
	parameter int widthX = `LAU_WIDTH_X,
	parameter int widthY = `LAU_WIDTH_Y,
	parameter lau_pkg::speed_e speed = `LAU_SPEED
) (
	input logic clk,
	input logic arstN,
	// one-cycle pulse, operands valid with it
	input logic inStrobe,
	input logic [widthX-1:0] xs,
	input logic [widthX-1:0] xc,
	input logic [widthY-1:0] y,
	// one-cycle pulse two edges after the sampled inStrobe
	output logic outStrobe,
	output logic [widthX+widthY-1:0] product,
	// xs + xc did not fit in widthX bits
	output logic sumOverflow
);

	// operand register
	logic [widthX-1:0] xsReg;
	logic [widthX-1:0] xcReg;
	logic [widthY-1:0] yReg;
	// operand register holds a live operation
	logic stageValid;

	// combinational results of stage two
	logic [widthX+widthY-1:0] productComb;
	logic overflowComb;

	// operands only move on a strobe
	always_ff @(posedge clk) begin
		if (inStrobe) begin
			xsReg <= xs;
			xcReg <= xc;
			yReg <= y;
		end
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			stageValid <= 1'b0;
		end else begin
			stageValid <= inStrobe;
		end
	end

	// multiplier datapath between the two registers
	AddMulUns #(
		.widthX(widthX),
		.widthY(widthY),
		.speed (speed)
	) mulCore (
		.xs(xsReg),
		.xc(xcReg),
		.y (yReg),
		.p (productComb)
	);

	// carry out of xs + xc
	// happens exactly when xc exceeds the room left above xs
	assign overflowComb = xcReg > ~xsReg;

	// result register
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			outStrobe <= 1'b0;
			product <= '0;
			sumOverflow <= 1'b0;
		end else begin
			outStrobe <= stageValid;
			// hold the last result between pulses
			if (stageValid) begin
				product <= productComb;
				sumOverflow <= overflowComb;
			end
		end
	end

endmodule

// File: tb/tbAddMulUnit.sv
`timescale 1ns/1ps
`include "lau_settings.svh"

module tbAddMulUnit;

	localparam int widthX = `LAU_WIDTH_X;
	localparam int widthY = `LAU_WIDTH_Y;
	localparam int widthP = widthX + widthY;

	logic clk;
	logic arstN;
	logic inStrobe;
	logic [widthX-1:0] xs;
	logic [widthX-1:0] xc;
	logic [widthY-1:0] y;
	logic outStrobe;
	logic [widthP-1:0] product;
	logic sumOverflow;
	// outputs of the ripple variant
	logic outStrobeSlow;
	logic [widthP-1:0] productSlow;
	logic sumOverflowSlow;

	// overflow flag on top, product below
	logic [widthP:0] expQ [$];
	// strobes seen two cycles back in bit 1 and one cycle back in bit 0
	logic [1:0] strobeHist;
	logic [15:0] lfsrState;
	string testName;
	int errorCount;
	int slowErrors;
	int sentCount;
	int resultCount;
	int testCount;
	int testErrStart;
	int sentStart;
	int resultStart;

	AddMulUnit dut (
		.clk(clk), .arstN(arstN), .inStrobe(inStrobe),
		.xs(xs), .xc(xc), .y(y),
		.outStrobe(outStrobe), .product(product), .sumOverflow(sumOverflow)
	);

	// ripple adders and linear compressor chain on the same stimulus
	AddMulUnit #(.speed(lau_pkg::SLOW)) dutSlow (
		.clk(clk), .arstN(arstN), .inStrobe(inStrobe),
		.xs(xs), .xc(xc), .y(y),
		.outStrobe(outStrobeSlow), .product(productSlow), .sumOverflow(sumOverflowSlow)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// (xs + xc) * y wrapped to the product width, flag when the sum needs widthX+1 bits
	function automatic logic [widthP:0] refResult(
		input logic [widthX-1:0] a,
		input logic [widthX-1:0] b,
		input logic [widthY-1:0] m
	);
		logic [widthX:0] sum;
		logic [widthP:0] full;
		sum = {1'b0, a} + {1'b0, b};
		full = (widthP + 1)'(sum) * (widthP + 1)'(m);
		return {sum[widthX], full[widthP-1:0]};
	endfunction

	// galois lfsr, taps 16 14 13 11
	function automatic logic [15:0] lfsrStep(input logic [15:0] state);
		if (state[0]) begin
			return (state >> 1) ^ 16'hB400;
		end
		return state >> 1;
	endfunction

	// one lfsr step per bit taken
	task automatic drawBits(input int n, output logic [31:0] value);
		value = '0;
		for (int k = 0; k < n; k++) begin
			value = {value[30:0], lfsrState[0]};
			lfsrState = lfsrStep(lfsrState);
		end
	endtask

	task automatic checkProduct(input string what, input logic [widthP-1:0] expected,
		input logic [widthP-1:0] actual);
		if (actual !== expected) begin
			$display("** Error %s: %s expected %h actual %h", testName, what, expected, actual);
			errorCount++;
		end
	endtask

	task automatic checkFlag(input string what, input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("** Error %s: %s expected %b actual %b", testName, what, expected, actual);
			errorCount++;
		end
	endtask

	task automatic sendOp(input logic [widthX-1:0] a, input logic [widthX-1:0] b,
		input logic [widthY-1:0] m);
		@(posedge clk);
		inStrobe <= 1'b1;
		xs <= a;
		xc <= b;
		y <= m;
	endtask

	// one strobe with fresh random operands, xs drawn first
	task automatic sendRandomOp();
		logic [31:0] v;
		logic [widthX-1:0] a;
		logic [widthX-1:0] b;
		drawBits(widthX, v);
		a = v[widthX-1:0];
		drawBits(widthX, v);
		b = v[widthX-1:0];
		drawBits(widthY, v);
		sendOp(a, b, v[widthY-1:0]);
	endtask

	task automatic idleCycles(input int n);
		repeat (n) begin
			@(posedge clk);
			inStrobe <= 1'b0;
		end
	endtask

	// every pending result has to show up within limit cycles
	task automatic waitDrain(input int limit);
		int n;
		n = 0;
		while (expQ.size() != 0 && n < limit) begin
			@(posedge clk);
			n++;
		end
		if (expQ.size() != 0) begin
			$display("test %s timed out with %0d results never delivered", testName, expQ.size());
			errorCount++;
			expQ.delete();
		end
		// a few quiet cycles to catch stray pulses
		idleCycles(3);
	endtask

	task automatic startTest(input string name);
		testName = name;
		testErrStart = errorCount;
		sentStart = sentCount;
		resultStart = resultCount;
	endtask

	task automatic finishTest();
		if (resultCount - resultStart != sentCount - sentStart) begin
			$display("test %s delivered %0d results for %0d operations", testName,
				resultCount - resultStart, sentCount - sentStart);
			errorCount++;
		end
		testCount++;
		$display("test %-10s ops %4d  errors %0d  %s", testName, sentCount - sentStart,
			errorCount - testErrStart, (errorCount == testErrStart) ? "ok" : "bad");
	endtask

	// expectations pushed and results compared half a cycle away from the edges
	always @(negedge clk) begin : scoreboard
		logic [widthP:0] expected;
		int errBefore;
		if (!arstN) begin
			strobeHist = '0;
		end else begin
			if (inStrobe) begin
				expQ.push_back(refResult(xs, xc, y));
				sentCount++;
			end
			// a strobe seen here is sampled on the next edge, result follows one edge later
			checkFlag("outStrobe", strobeHist[1], outStrobe);
			errBefore = errorCount;
			checkFlag("slow outStrobe", strobeHist[1], outStrobeSlow);
			slowErrors += errorCount - errBefore;
			strobeHist = {strobeHist[0], inStrobe};
			if (outStrobe) begin
				if (expQ.size() == 0) begin
					$display("test %s saw an outStrobe with no operation pending", testName);
					errorCount++;
				end else begin
					expected = expQ.pop_front();
					resultCount++;
					checkProduct("product", expected[widthP-1:0], product);
					checkFlag("sumOverflow", expected[widthP], sumOverflow);
					errBefore = errorCount;
					checkProduct("slow product", expected[widthP-1:0], productSlow);
					checkFlag("slow sumOverflow", expected[widthP], sumOverflowSlow);
					slowErrors += errorCount - errBefore;
				end
			end
		end
	end

	initial begin : mainFlow
		logic [31:0] v;
		logic [widthX-1:0] xMax;
		int edges;
		logic seen;
		xMax = '1;
		arstN = 1'b0;
		inStrobe = 1'b0;
		xs = '0;
		xc = '0;
		y = '0;
		lfsrState = 16'd45;
		errorCount = 0;
		slowErrors = 0;
		sentCount = 0;
		resultCount = 0;
		testCount = 0;

		startTest("reset");
		repeat (4) @(posedge clk);
		arstN <= 1'b1;
		@(negedge clk);
		checkFlag("outStrobe", 1'b0, outStrobe);
		checkProduct("product", '0, product);
		checkFlag("sumOverflow", 1'b0, sumOverflow);
		checkFlag("slow outStrobe", 1'b0, outStrobeSlow);
		checkProduct("slow product", '0, productSlow);
		checkFlag("slow sumOverflow", 1'b0, sumOverflowSlow);
		finishTest();

		// zeros, largest value without overflow, largest sum with wrap
		startTest("corners");
		sendOp('0, '0, '0);
		sendOp(xMax, '0, '1);
		sendOp(xMax, xMax, '1);
		idleCycles(1);
		waitDrain(20);
		finishTest();

		// counted from the drive edge, the first counted edge samples the strobe
		startTest("latency");
		sendOp(8'h5A, 8'h33, 8'hC7);
		@(posedge clk);
		inStrobe <= 1'b0;
		edges = 1;
		@(negedge clk);
		seen = outStrobe;
		while (!seen && edges < 8) begin
			@(posedge clk);
			edges++;
			@(negedge clk);
			seen = outStrobe;
		end
		if (!seen) begin
			$display("test latency: outStrobe never rose within 8 cycles");
			errorCount++;
		end else if (edges != 2) begin
			$display("** Error latency: edges expected 2 actual %0d", edges);
			errorCount++;
		end
		@(negedge clk);
		if (outStrobe) begin
			$display("test latency: outStrobe stayed high for more than one cycle");
			errorCount++;
		end
		waitDrain(10);
		finishTest();

		startTest("backToBack");
		for (int k = 0; k < 200; k++) begin
			sendRandomOp();
		end
		idleCycles(1);
		waitDrain(20);
		finishTest();

		// random idle gaps of zero to three cycles
		startTest("gapped");
		for (int k = 0; k < 150; k++) begin
			sendRandomOp();
			drawBits(2, v);
			idleCycles(v[1:0]);
		end
		idleCycles(1);
		waitDrain(20);
		finishTest();

		// the ripple instance was checked alongside every test above
		testCount++;
		$display("test %-10s ops %4d  errors %0d  %s", "slowSpeed", resultCount, slowErrors,
			(slowErrors == 0) ? "ok" : "bad");

		$display("tests %0d  operations %0d  results %0d  errors %0d", testCount, sentCount,
			resultCount, errorCount);
		if (errorCount == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

// File: addMulUnit.f
+incdir+logic
logic/lau_pkg.sv
logic/AddMulPPGenUns.sv
logic/AddMopCsv.sv
logic/Add.sv
logic/AddMulUns.sv
logic/AddMulUnit.sv
tb/tbAddMulUnit.sv

// File: runSim.sh
#!/bin/sh
# build the testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing -Wno-fatal -f addMulUnit.f --top-module tbAddMulUnit \
	-o simAddMulUnit || exit 1

./obj_dir/simAddMulUnit > sim.log 2>&1
cat sim.log

# the log decides the outcome
test -s sim.log || exit 1
grep -q "Simulation FAILED" sim.log && exit 1 || exit 0
